// File: rtl/kv_consts.svh
// Sizes are fixed at build time and KV_DEPTH must equal 2**KV_KEY_W for the direct-mapped table
`ifndef KV_CONSTS_SVH
`define KV_CONSTS_SVH

// ----------------------------------------------------------------------
// Table geometry
// ----------------------------------------------------------------------
`define KV_KEY_W 5
`define KV_DEPTH 32
`define KV_VALUE_W 16

// ----------------------------------------------------------------------
// Timing
// ----------------------------------------------------------------------
// Latency of each request pipe in cycles, at least 1
`define KV_PIPE_DEPTH 2

// Cycles init_done must stay high before the sequencer trusts it, at least 2
`define KV_DEBOUNCE_CNT 8

// Sequencer gives up on a command after this many busy cycles
`define KV_TIMEOUT_CYCLES 24

`endif

// File: rtl/kv_cmd_pkg.sv
// Controller-side types; command code 7 is not assigned and is treated as illegal by the sequencer
`include "kv_consts.svh"

package kv_cmd_pkg;

    // Controller command codes
    typedef enum logic [2:0] {
        COMMAND_NOP      = 3'd0,
        COMMAND_CLEAR    = 3'd1,
        COMMAND_GET      = 3'd2,
        COMMAND_GET_NEXT = 3'd3,
        COMMAND_UNSET    = 3'd4,
        COMMAND_REPLACE  = 3'd5,
        COMMAND_SET      = 3'd6
    } kv_command_t;

    typedef enum logic [1:0] {
        STATUS_OK      = 2'd0,
        STATUS_ERROR   = 2'd1,
        STATUS_TIMEOUT = 2'd2
    } kv_status_t;

    // Request held by the controller until accepted
    typedef struct packed {
        kv_command_t              command;
        logic [`KV_KEY_W-1:0]     key;
        logic [`KV_VALUE_W-1:0]   set_value;
    } kv_ctrl_req_t;

    // Response, valid from the ack cycle onward
    typedef struct packed {
        kv_status_t               status;
        logic                     get_valid;
        logic [`KV_KEY_W-1:0]     get_key;
        logic [`KV_VALUE_W-1:0]   get_value;
    } kv_ctrl_resp_t;

endpackage : kv_cmd_pkg

// File: rtl/kv_mem_pkg.sv
// Store-side request and response types shared by the sequencer, the request pipes and the store
`include "kv_consts.svh"

package kv_mem_pkg;

    // Write request, valid cleared for UNSET
    typedef struct packed {
        logic [`KV_KEY_W-1:0]     key;
        logic                     valid;
        logic [`KV_VALUE_W-1:0]   value;
    } kv_wr_req_t;

    // Read request, next set for GET_NEXT
    typedef struct packed {
        logic [`KV_KEY_W-1:0]     key;
        logic                     next;
    } kv_rd_req_t;

    // Read answer
    // next_key is the entry found, or the requested key for a plain read
    typedef struct packed {
        logic                     valid;
        logic [`KV_VALUE_W-1:0]   value;
        logic [`KV_KEY_W-1:0]     next_key;
    } kv_rd_resp_t;

endpackage : kv_mem_pkg

// File: rtl/kv_req_pipe.sv
// Fixed-latency pipe with no back-pressure; DEPTH must be at least 1
`timescale 1ns/100ps

module kv_req_pipe #(
    parameter type T     = logic,
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic srst,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    logic [DEPTH-1:0] valid_sr;
    T                 data_sr [DEPTH];

    // Strobe stages
    always_ff @(posedge clk) begin
        if (srst) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    // Payload stages
    always_ff @(posedge clk) begin
        data_sr[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign out_valid = valid_sr[DEPTH-1];
    assign out_data  = data_sr[DEPTH-1];

endmodule : kv_req_pipe

// File: rtl/kv_store.sv
// Direct-mapped table indexed by key; at most one request per pipe may be in flight
`timescale 1ns/100ps
`include "kv_consts.svh"

module kv_store
    import kv_mem_pkg::*;
(
    input  logic        clk,
    input  logic        srst,
    input  logic        init,
    input  logic        wr_strobe,
    input  kv_wr_req_t  wr_in,
    input  logic        rd_strobe,
    input  kv_rd_req_t  rd_in,
    input  logic        wr_issue,
    input  logic        rd_issue,
    output logic        wr_rdy,
    output logic        rd_rdy,
    output logic        wr_ack,
    output logic        rd_ack,
    output kv_rd_resp_t rd_resp,
    output logic        init_done
);

    localparam int               KEY_W   = `KV_KEY_W;
    localparam logic [KEY_W-1:0] KEY_MAX = KEY_W'(`KV_DEPTH - 1);

    logic [`KV_DEPTH-1:0]   valid_bits;
    logic [`KV_VALUE_W-1:0] values [`KV_DEPTH];
    logic                   scanning;
    logic [KEY_W-1:0]       scan_key;
    logic                   scan_hit;
    logic                   scan_miss;
    logic [1:0]             issue_v;
    logic [1:0]             strobe_v;
    logic [1:0]             busy;
    logic [1:0]             stale;
    logic                   wr_go;
    logic                   rd_go;
    logic                   rd_direct;
    logic                   rd_last;
    logic                   rd_scan;

    // ----------------------------------------------------------------------
    // In-flight tracking, bit 0 write pipe and bit 1 read pipe
    // ----------------------------------------------------------------------
    assign issue_v  = {rd_issue, wr_issue};
    assign strobe_v = {rd_strobe, wr_strobe};

    // A request caught in the pipe by init is discarded on arrival
    always_ff @(posedge clk) begin
        if (srst) begin
            busy  <= '0;
            stale <= '0;
        end else begin
            busy  <= issue_v | (busy & ~strobe_v);
            stale <= ~strobe_v & (stale | (busy & {2{init}}));
        end
    end

    assign wr_rdy = !scanning && (busy == 2'b00);
    assign rd_rdy = wr_rdy;

    assign wr_go     = wr_strobe && !stale[0] && !init;
    assign rd_go     = rd_strobe && !stale[1] && !init;
    assign rd_direct = rd_go && !rd_in.next;
    assign rd_last   = rd_go && rd_in.next && (rd_in.key == KEY_MAX);
    assign rd_scan   = rd_go && rd_in.next && (rd_in.key != KEY_MAX);

    // Scan looks at one entry per cycle
    assign scan_hit  = scanning && valid_bits[scan_key];
    assign scan_miss = scanning && !valid_bits[scan_key] && (scan_key == KEY_MAX);

    // ----------------------------------------------------------------------
    // Control and valid bits
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst || init) begin
            valid_bits <= '0;
            scanning   <= 1'b0;
            wr_ack     <= 1'b0;
            rd_ack     <= 1'b0;
            init_done  <= 1'b0;
        end else begin
            init_done <= 1'b1;
            wr_ack    <= wr_go;
            rd_ack    <= rd_direct || rd_last || scan_hit || scan_miss;
            if (wr_go) begin
                valid_bits[wr_in.key] <= wr_in.valid;
            end
            if (rd_scan) begin
                scanning <= 1'b1;
                scan_key <= rd_in.key + 1'b1;
            end else if (scan_hit || scan_miss) begin
                scanning <= 1'b0;
            end else if (scanning) begin
                scan_key <= scan_key + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Value memory and read data
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_go) begin
            values[wr_in.key] <= wr_in.value;
        end
    end

    // Reads see the old entry when a write lands in the same cycle
    always_ff @(posedge clk) begin
        if (rd_direct) begin
            rd_resp.valid    <= valid_bits[rd_in.key];
            rd_resp.value    <= values[rd_in.key];
            rd_resp.next_key <= rd_in.key;
        end else if (scan_hit) begin
            rd_resp.valid    <= 1'b1;
            rd_resp.value    <= values[scan_key];
            rd_resp.next_key <= scan_key;
        end else if (rd_last || scan_miss) begin
            rd_resp <= '0;
        end
    end

endmodule : kv_store

// File: rtl/kv_peripheral.sv
// One command at a time; TIMEOUT_CYCLES of 0 disables the timer and KV_DEBOUNCE_CNT must be >= 2
`timescale 1ns/100ps
`include "kv_consts.svh"

module kv_peripheral
    import kv_cmd_pkg::*, kv_mem_pkg::*;
#(
    parameter int TIMEOUT_CYCLES = 0
) (
    input  logic          clk,
    input  logic          srst,
    // Controller side
    input  kv_ctrl_req_t  ctrl_req,
    input  logic          req,
    output logic          rdy,
    output logic          ack,
    output kv_ctrl_resp_t resp,
    // Store side
    output logic          init,
    input  logic          init_done,
    output logic          wr_req,
    output kv_wr_req_t    wr_fields,
    input  logic          wr_rdy,
    input  logic          wr_ack,
    output logic          wr_issue,
    output logic          rd_req,
    output kv_rd_req_t    rd_fields,
    input  logic          rd_rdy,
    input  logic          rd_ack,
    input  kv_rd_resp_t   rd_resp,
    output logic          rd_issue
);

    localparam int DB_W = $clog2(`KV_DEBOUNCE_CNT);

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        CLEAR,
        RD,
        RMW,
        WR,
        CLEAR_PENDING,
        RD_PENDING,
        WR_PENDING,
        DONE,
        ERROR,
        TIMEOUT
    } state_t;

    state_t                 state;
    state_t                 nxt_state;
    state_t                 state_d;
    logic                   reset_timer;
    logic                   inc_timer;
    logic                   timeout;
    logic                   init_done_db;
    logic [DB_W-1:0]        db_cnt;
    kv_status_t             status_q;
    logic                   get_valid_q;
    logic [`KV_KEY_W-1:0]   get_key_q;
    logic [`KV_VALUE_W-1:0] get_value_q;

    // ----------------------------------------------------------------------
    // Command FSM
    // ----------------------------------------------------------------------
    assign state_d = timeout ? TIMEOUT : nxt_state;

    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= state_d;
        end
    end

    always_comb begin
        nxt_state   = state;
        reset_timer = 1'b0;
        inc_timer   = 1'b0;
        init        = 1'b0;
        wr_req      = 1'b0;
        rd_req      = 1'b0;
        case (state)
            RESET: begin
                if (init_done_db) nxt_state = IDLE;
            end
            IDLE: begin
                reset_timer = 1'b1;
                if (req) begin
                    case (ctrl_req.command)
                        COMMAND_NOP:                     nxt_state = DONE;
                        COMMAND_CLEAR:                   nxt_state = CLEAR;
                        COMMAND_GET, COMMAND_GET_NEXT:   nxt_state = RD;
                        COMMAND_UNSET, COMMAND_REPLACE:  nxt_state = RMW;
                        COMMAND_SET:                     nxt_state = WR;
                        default:                         nxt_state = ERROR;
                    endcase
                end
            end
            CLEAR: begin
                inc_timer = 1'b1;
                init      = 1'b1;
                nxt_state = CLEAR_PENDING;
            end
            RD: begin
                inc_timer = 1'b1;
                rd_req    = 1'b1;
                if (rd_rdy) nxt_state = RD_PENDING;
            end
            RMW: begin
                inc_timer = 1'b1;
                wr_req    = 1'b1;
                rd_req    = 1'b1;
                if (wr_rdy && rd_rdy) nxt_state = RD_PENDING;
            end
            WR: begin
                inc_timer = 1'b1;
                wr_req    = 1'b1;
                if (wr_rdy) nxt_state = WR_PENDING;
            end
            CLEAR_PENDING: begin
                inc_timer = 1'b1;
                if (init_done_db) nxt_state = DONE;
            end
            RD_PENDING: begin
                inc_timer = 1'b1;
                if (rd_ack) nxt_state = DONE;
            end
            WR_PENDING: begin
                inc_timer = 1'b1;
                if (wr_ack) nxt_state = DONE;
            end
            DONE, ERROR, TIMEOUT: begin
                nxt_state = IDLE;
            end
            default: begin
                nxt_state = ERROR;
            end
        endcase
    end

    assign rdy = (state == IDLE);
    assign ack = (state == DONE) || (state == ERROR) || (state == TIMEOUT);

    // RMW only issues when both sides can take it
    assign wr_issue = wr_req && wr_rdy && (!rd_req || rd_rdy);
    assign rd_issue = rd_req && rd_rdy && (!wr_req || wr_rdy);

    // ----------------------------------------------------------------------
    // Request and response latching
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (req && rdy) begin
            wr_fields.key   <= ctrl_req.key;
            wr_fields.valid <= (ctrl_req.command != COMMAND_UNSET);
            wr_fields.value <= (ctrl_req.command == COMMAND_UNSET) ? '0 : ctrl_req.set_value;
            rd_fields.key   <= ctrl_req.key;
            rd_fields.next  <= (ctrl_req.command == COMMAND_GET_NEXT);
        end
    end

    // Late answers after a timeout are ignored
    always_ff @(posedge clk) begin
        if ((state == RD_PENDING) && rd_ack) begin
            get_valid_q <= rd_resp.valid;
            get_key_q   <= rd_resp.next_key;
            get_value_q <= rd_resp.value;
        end
    end

    // Status is captured on entry to the ack state
    always_ff @(posedge clk) begin
        if (srst) begin
            status_q <= STATUS_OK;
        end else begin
            case (state_d)
                DONE:    status_q <= STATUS_OK;
                ERROR:   status_q <= STATUS_ERROR;
                TIMEOUT: status_q <= STATUS_TIMEOUT;
                default: status_q <= status_q;
            endcase
        end
    end

    assign resp = '{
        status:    status_q,
        get_valid: get_valid_q,
        get_key:   get_key_q,
        get_value: get_value_q
    };

    // ----------------------------------------------------------------------
    // init_done debounce and timeout timer
    // ----------------------------------------------------------------------
    // Pipe latency can leave a stale init_done high right after init
    always_ff @(posedge clk) begin
        if (srst || init) begin
            db_cnt <= '0;
        end else if (!init_done_db) begin
            db_cnt <= init_done ? db_cnt + 1'b1 : '0;
        end
    end

    assign init_done_db = (db_cnt == DB_W'(`KV_DEBOUNCE_CNT - 1));

    generate
        if (TIMEOUT_CYCLES > 0) begin : g_timeout
            localparam int TW = $clog2(TIMEOUT_CYCLES + 1);
            logic [TW-1:0] timer;

            always_ff @(posedge clk) begin
                if (srst || reset_timer) begin
                    timer <= '0;
                end else if (inc_timer) begin
                    timer <= timer + 1'b1;
                end
            end

            assign timeout = inc_timer && (timer == TW'(TIMEOUT_CYCLES - 1));
        end else begin : g_no_timeout
            assign timeout = 1'b0;
        end
    endgenerate

endmodule : kv_peripheral

// File: rtl/kv_top.sv
// Command front end over a direct-mapped table; the caller holds req and ctrl_req until rdy
`timescale 1ns/100ps
`include "kv_consts.svh"

module kv_top
    import kv_cmd_pkg::*, kv_mem_pkg::*;
(
    input  logic          clk,
    input  logic          srst,
    input  logic          req,
    input  kv_ctrl_req_t  ctrl_req,
    output logic          rdy,
    output logic          ack,
    output kv_ctrl_resp_t resp
);

    kv_wr_req_t  wr_fields;
    kv_wr_req_t  wr_pipe_data;
    kv_rd_req_t  rd_fields;
    kv_rd_req_t  rd_pipe_data;
    kv_rd_resp_t rd_resp;
    logic        wr_issue;
    logic        rd_issue;
    logic        wr_strobe;
    logic        rd_strobe;
    logic        wr_rdy;
    logic        rd_rdy;
    logic        wr_ack;
    logic        rd_ack;
    logic        init;
    logic        init_done;

    // ----------------------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------------------
    // Request levels stay internal, the pipes take the issue strobes
    kv_peripheral #(
        .TIMEOUT_CYCLES (`KV_TIMEOUT_CYCLES)
    ) u_peripheral (
        .clk       (clk),
        .srst      (srst),
        .ctrl_req  (ctrl_req),
        .req       (req),
        .rdy       (rdy),
        .ack       (ack),
        .resp      (resp),
        .init      (init),
        .init_done (init_done),
        .wr_req    (),
        .wr_fields (wr_fields),
        .wr_rdy    (wr_rdy),
        .wr_ack    (wr_ack),
        .wr_issue  (wr_issue),
        .rd_req    (),
        .rd_fields (rd_fields),
        .rd_rdy    (rd_rdy),
        .rd_ack    (rd_ack),
        .rd_resp   (rd_resp),
        .rd_issue  (rd_issue)
    );

    // ----------------------------------------------------------------------
    // Memory path
    // ----------------------------------------------------------------------
    kv_req_pipe #(
        .T     (kv_wr_req_t),
        .DEPTH (`KV_PIPE_DEPTH)
    ) u_wr_pipe (
        .clk       (clk),
        .srst      (srst),
        .in_valid  (wr_issue),
        .in_data   (wr_fields),
        .out_valid (wr_strobe),
        .out_data  (wr_pipe_data)
    );

    kv_req_pipe #(
        .T     (kv_rd_req_t),
        .DEPTH (`KV_PIPE_DEPTH)
    ) u_rd_pipe (
        .clk       (clk),
        .srst      (srst),
        .in_valid  (rd_issue),
        .in_data   (rd_fields),
        .out_valid (rd_strobe),
        .out_data  (rd_pipe_data)
    );

    kv_store u_store (
        .clk       (clk),
        .srst      (srst),
        .init      (init),
        .wr_strobe (wr_strobe),
        .wr_in     (wr_pipe_data),
        .rd_strobe (rd_strobe),
        .rd_in     (rd_pipe_data),
        .wr_issue  (wr_issue),
        .rd_issue  (rd_issue),
        .wr_rdy    (wr_rdy),
        .rd_rdy    (rd_rdy),
        .wr_ack    (wr_ack),
        .rd_ack    (rd_ack),
        .rd_resp   (rd_resp),
        .init_done (init_done)
    );

endmodule : kv_top

// File: tests/kv_tb.sv
// Reads tests/kv_stim.txt from the project root; rows run in order and each waits for its ack
`timescale 1ns/100ps
`include "kv_consts.svh"

module kv_tb
    import kv_cmd_pkg::*;
();

    // One stimulus row with its expected response
    typedef struct packed {
        logic [2:0]             cmd;
        logic [`KV_KEY_W-1:0]   key;
        logic [`KV_VALUE_W-1:0] set_value;
        logic [1:0]             exp_status;
        logic                   exp_valid;
        logic [`KV_KEY_W-1:0]   exp_key;
        logic [`KV_VALUE_W-1:0] exp_value;
    } stim_row_t;

    logic          clk;
    logic          srst;
    logic          req;
    kv_ctrl_req_t  ctrl_req;
    logic          rdy;
    logic          ack;
    kv_ctrl_resp_t resp;

    stim_row_t     rows [$];
    string         names [$];
    int            errors = 0;
    int            checks = 0;
    int            cycles = 0;
    int            cycle_limit = 100;
    int            row_idx = 0;

    kv_top uut (
        .clk      (clk),
        .srst     (srst),
        .req      (req),
        .ctrl_req (ctrl_req),
        .rdy      (rdy),
        .ack      (ack),
        .resp     (resp)
    );

    always #2 clk = ~clk;

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------
    // Commands whose response carries a table entry
    function automatic bit returns_entry(input logic [2:0] cmd);
        return (cmd == COMMAND_GET) || (cmd == COMMAND_GET_NEXT) ||
               (cmd == COMMAND_UNSET) || (cmd == COMMAND_REPLACE);
    endfunction

    task automatic load_stim();
        int        fd;
        int        r;
        string     tok;
        string     rest;
        int        f_cmd, f_key, f_set, f_st, f_v, f_k, f_val;
        stim_row_t row;
        fd = $fopen("tests/kv_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file tests/kv_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            r = $fscanf(fd, "%s", tok);
            if (r != 1) break;
            if (tok.getc(0) == "#") begin
                r = $fgets(rest, fd);
            end else begin
                r = $fscanf(fd, "%h %h %h %h %h %h %h",
                            f_cmd, f_key, f_set, f_st, f_v, f_k, f_val);
                if (r != 7) begin
                    errors++;
                    $display("Stimulus row %s has missing or unreadable fields", tok);
                    break;
                end
                row.cmd        = f_cmd[2:0];
                row.key        = f_key[`KV_KEY_W-1:0];
                row.set_value  = f_set[`KV_VALUE_W-1:0];
                row.exp_status = f_st[1:0];
                row.exp_valid  = f_v[0];
                row.exp_key    = f_k[`KV_KEY_W-1:0];
                row.exp_value  = f_val[`KV_VALUE_W-1:0];
                rows.push_back(row);
                names.push_back(tok);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_resp(input string name, input stim_row_t row);
        checks++;
        assert (resp.status == row.exp_status) else begin
            errors++;
            $display("[FAIL] %s status expected %0d actual %0d",
                     name, row.exp_status, resp.status);
        end
        if ((row.exp_status == STATUS_OK) && returns_entry(row.cmd)) begin
            checks += 2;
            assert (resp.get_valid == row.exp_valid) else begin
                errors++;
                $display("[FAIL] %s get_valid expected %0d actual %0d",
                         name, row.exp_valid, resp.get_valid);
            end
            assert (resp.get_key == row.exp_key) else begin
                errors++;
                $display("[FAIL] %s get_key expected %0h actual %0h",
                         name, row.exp_key, resp.get_key);
            end
            // Empty entries carry no defined value
            if (row.exp_valid) begin
                checks++;
                assert (resp.get_value == row.exp_value) else begin
                    errors++;
                    $display("[FAIL] %s get_value expected %h actual %h",
                             name, row.exp_value, resp.get_value);
                end
            end
        end
    endtask

    // Hold req until rdy is seen, then wait for the ack cycle
    task automatic run_row(input int idx);
        stim_row_t row;
        row = rows[idx];
        @(negedge clk);
        ctrl_req.command   = kv_command_t'(row.cmd);
        ctrl_req.key       = row.key;
        ctrl_req.set_value = row.set_value;
        req = 1'b1;
        while (!rdy) @(negedge clk);
        // Taken on the rising edge in between
        @(negedge clk);
        req = 1'b0;
        // No new command is taken until the current one is acked
        checks++;
        forever begin
            assert (!rdy) else begin
                errors++;
                $display("[FAIL] %s rdy while busy expected 0 actual %0d", names[idx], rdy);
            end
            if (ack) break;
            @(negedge clk);
        end
        check_resp(names[idx], row);
        // ack lasts a single cycle
        @(negedge clk);
        checks++;
        assert (!ack) else begin
            errors++;
            $display("[FAIL] %s ack after one cycle expected 0 actual %0d", names[idx], ack);
        end
    endtask

    task automatic finish_run();
        $display("Rows: %0d  checks: %0d  errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    endtask

    // ----------------------------------------------------------------------
    // Watchdog and main sequence
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            errors++;
            $display("Run stopped at the cycle limit of %0d while row %0d was unfinished",
                     cycle_limit, row_idx);
            finish_run();
        end
    end

    initial begin
        clk      = 1'b0;
        srst     = 1'b1;
        req      = 1'b0;
        ctrl_req = '0;
        load_stim();
        if (rows.size() == 0) begin
            errors++;
            $display("No stimulus rows were loaded");
        end
        cycle_limit = 60 * rows.size() + 100;
        repeat (4) @(posedge clk);
        @(negedge clk);
        srst = 1'b0;
        for (row_idx = 0; row_idx < rows.size(); row_idx++) begin
            run_row(row_idx);
        end
        finish_run();
    end

endmodule : kv_tb

// File: tests/kv_stim.txt
# name cmd key set_value | exp_status exp_valid exp_key exp_value (all numbers hex)
# cmd 0 NOP 1 CLEAR 2 GET 3 GET_NEXT 4 UNSET 5 REPLACE 6 SET 7 illegal; status 0 OK 1 ERROR 2 TIMEOUT
get_empty_00    2 00 0000 0 0 00 0000
get_empty_1f    2 1f 0000 0 0 1f 0000
set_03          6 03 a5a5 0 0 00 0000
get_03          2 03 0000 0 1 03 a5a5
set_05          6 05 1234 0 0 00 0000
set_06          6 06 beef 0 0 00 0000
get_05          2 05 0000 0 1 05 1234
replace_05      5 05 4321 0 1 05 1234
get_05_new      2 05 0000 0 1 05 4321
next_from_03    3 03 0000 0 1 05 4321
next_from_05    3 05 0000 0 1 06 beef
unset_06        4 06 0000 0 1 06 beef
get_06_gone     2 06 0000 0 0 06 0000
set_1f          6 1f c0de 0 0 00 0000
clear_all       1 00 0000 0 0 00 0000
get_03_cleared  2 03 0000 0 0 03 0000
get_1f_cleared  2 1f 0000 0 0 1f 0000
next_timeout    3 00 0000 2 0 00 0000
clear_after_to  1 00 0000 0 0 00 0000
get_00_after    2 00 0000 0 0 00 0000
nop             0 00 0000 0 0 00 0000
illegal_7       7 00 0000 1 0 00 0000

// File: list.f
+incdir+rtl
rtl/kv_cmd_pkg.sv
rtl/kv_mem_pkg.sv
rtl/kv_req_pipe.sv
rtl/kv_store.sv
rtl/kv_peripheral.sv
rtl/kv_top.sv
tests/kv_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module kv_tb -f list.f -o kv_sim

out=$(./obj_dir/kv_sim)
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1
